/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// Harness memory map, each region is 256 MiB
	localparam logic [ADDR_W-1:0] CODE_BASE   = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] DATA_BASE   = 32'h2000_0000;
	localparam logic [ADDR_W-1:0] REGION_MASK = 32'hF000_0000; // Top nibble only

	// AHB transfer type
	typedef enum logic [1:0] {
		TR_IDLE   = 2'b00,
		TR_BUSY   = 2'b01,
		TR_NONSEQ = 2'b10,
		TR_SEQ    = 2'b11
	} htrans_e;

	// AHB transfer size, anything above WORD is unsupported
	typedef enum logic [2:0] {
		SZ_BYTE = 3'b000,
		SZ_HALF = 3'b001,
		SZ_WORD = 3'b010
	} hsize_e;

	// Bridge controller states
	typedef enum logic [2:0] {
		S_IDLE  = 3'd0,
		S_WDATA = 3'd1, // Waiting for hwdata
		S_BUS   = 3'd2, // Wishbone cycle open
		S_DONE  = 3'd3,
		S_ERR1  = 3'd4,
		S_ERR2  = 3'd5
	} bridge_state_e;

	// Decoded Wishbone target
	typedef enum logic [1:0] {
		REG_CODE = 2'd0,
		REG_DATA = 2'd1,
		REG_NONE = 2'd2
	} region_e;

endpackage

`default_nettype wire

/* design/ahb_wb_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ahb_wb_ctrl
	import bus_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_n_i,

	// AHB address phase
	input  htrans_e htrans_i,
	input  logic    hready_in_ok_i, // Write flag of the phase from the datapath

	// Flags for the transfer being accepted
	input  logic    misalign_i,
	input  logic    unmapped_i,

	// Selected Wishbone port
	input  logic    bus_ack_i,

	// AHB response
	output logic    hready_o,
	output logic    hresp_o,

	// Datapath capture strobes
	output logic    addr_load_o,
	output logic    wdata_load_o,
	output logic    rdata_load_o,

	// Wishbone request
	output logic    bus_req_o,
	output logic    bus_we_o
);

	bridge_state_e state_q;
	bridge_state_e state_d;
	logic          accept;
	logic          bad_xfer;

	// New address phase seen while the bridge is ready
	assign accept   = hready_o && (htrans_i == TR_NONSEQ || htrans_i == TR_SEQ);
	assign bad_xfer = misalign_i || unmapped_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE:  state_d = S_IDLE;
			S_WDATA: state_d = S_BUS; // hwdata is captured this cycle
			S_BUS: begin
				if (bus_ack_i)
					state_d = S_DONE;
			end
			S_DONE:  state_d = S_IDLE;
			S_ERR1:  state_d = S_ERR2;
			S_ERR2:  state_d = S_IDLE;
			default: state_d = S_IDLE;
		endcase

		// Only IDLE, DONE and ERR2 can accept, so this overrides the return to IDLE
		if (accept) begin
			if (bad_xfer)
				state_d = S_ERR1;
			else if (hready_in_ok_i)
				state_d = S_WDATA;
			else
				state_d = S_BUS;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= S_IDLE;
		else
			state_q <= state_d;
	end

	// hready low only while a transfer is in flight or in the first error cycle
	assign hready_o = (state_q == S_IDLE) || (state_q == S_DONE) || (state_q == S_ERR2);
	assign hresp_o  = (state_q == S_ERR1) || (state_q == S_ERR2);

	assign addr_load_o  = accept;
	assign wdata_load_o = (state_q == S_WDATA);
	assign bus_req_o    = (state_q == S_BUS);
	assign rdata_load_o = bus_req_o && bus_ack_i; // Sample on the ack edge
	assign bus_we_o     = bus_req_o && hready_in_ok_i;

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		hresp_o |-> (state_q inside {S_ERR1, S_ERR2}))
		else $error("hresp raised outside the error states");

	// Wishbone request is never withdrawn before the slave acks
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(bus_req_o && !bus_ack_i) |=> bus_req_o)
		else $error("Wishbone cycle dropped before ack");

endmodule

`default_nettype wire

/* design/ahb_wb_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module ahb_wb_datapath
	import bus_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,

	// AHB address and data phase
	input  logic [ADDR_W-1:0] haddr_i,
	input  logic              hwrite_i,
	input  hsize_e            hsize_i,
	input  logic [DATA_W-1:0] hwdata_i,

	// Capture strobes from the controller
	input  logic              addr_load_i,
	input  logic              wdata_load_i,
	input  logic              rdata_load_i,

	// Read data from the selected Wishbone port
	input  logic [DATA_W-1:0] bus_rdata_i,

	output logic [ADDR_W-1:0] addr_o,
	output logic              we_o,
	output logic [STRB_W-1:0] wstrb_o,
	output logic [DATA_W-1:0] wdata_o,
	output logic [DATA_W-1:0] hrdata_o,
	output logic              misalign_o
);

	logic [ADDR_W-1:0] addr_q;
	logic              we_q;
	hsize_e            size_q;
	hsize_e            size_cur;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;

	// Address phase registers
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			addr_q <= '0;
			we_q   <= 1'b0;
			size_q <= SZ_WORD;
		end else if (addr_load_i) begin
			addr_q <= haddr_i;
			we_q   <= hwrite_i;
			size_q <= hsize_i;
		end
	end

	// The phase being accepted shows through, so the controller can route on the accept edge.
	// Outside of acceptance the latched values hold still for the Wishbone cycle.
	assign addr_o   = addr_load_i ? haddr_i : addr_q;
	assign we_o     = addr_load_i ? hwrite_i : we_q;
	assign size_cur = addr_load_i ? hsize_i : size_q;

	// Byte lanes from size and low address bits
	always_comb begin
		case (size_cur)
			SZ_BYTE: wstrb_o = STRB_W'(1) << addr_o[1:0];
			SZ_HALF: wstrb_o = addr_o[1] ? 4'b1100 : 4'b0011;
			SZ_WORD: wstrb_o = 4'b1111;
			default: wstrb_o = '0; // Never reaches the bus
		endcase
	end

	always_comb begin
		case (size_cur)
			SZ_BYTE: misalign_o = 1'b0;
			SZ_HALF: misalign_o = addr_o[0];
			SZ_WORD: misalign_o = |addr_o[1:0];
			default: misalign_o = 1'b1; // Unsupported size
		endcase
	end

	// Write data arrives one cycle after the address phase
	always_ff @(posedge clk_i) begin
		if (wdata_load_i)
			wdata_q <= hwdata_i;
	end

	// Full word kept on its AHB lanes
	always_ff @(posedge clk_i) begin
		if (rdata_load_i)
			rdata_q <= bus_rdata_i;
	end

	assign wdata_o  = wdata_q;
	assign hrdata_o = rdata_q;

endmodule

`default_nettype wire

/* design/wb_port_select.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_port_select
	import bus_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,

	input  logic [ADDR_W-1:0] addr_i,
	input  logic              bus_req_i,

	// Code port return path
	input  logic              core_ack_i,
	input  logic [DATA_W-1:0] core_data_i,

	// Data port return path
	input  logic              data_mem_ack_i,
	input  logic [DATA_W-1:0] data_mem_data_i,

	output logic              unmapped_o,
	output logic              core_cyc_o,
	output logic              core_stb_o,
	output logic              data_mem_cyc_o,
	output logic              data_mem_stb_o,
	output logic              bus_ack_o,
	output logic [DATA_W-1:0] bus_rdata_o
);

	region_e region;

	always_comb begin
		if ((addr_i & REGION_MASK) == CODE_BASE)
			region = REG_CODE;
		else if ((addr_i & REGION_MASK) == DATA_BASE)
			region = REG_DATA;
		else
			region = REG_NONE;
	end

	assign unmapped_o = (region == REG_NONE);

	// cyc and stb travel together on the chosen port
	assign core_cyc_o     = bus_req_i && (region == REG_CODE);
	assign core_stb_o     = core_cyc_o;
	assign data_mem_cyc_o = bus_req_i && (region == REG_DATA);
	assign data_mem_stb_o = data_mem_cyc_o;

	always_comb begin
		case (region)
			REG_CODE: begin
				bus_ack_o   = core_ack_i;
				bus_rdata_o = core_data_i;
			end
			REG_DATA: begin
				bus_ack_o   = data_mem_ack_i;
				bus_rdata_o = data_mem_data_i;
			end
			default: begin
				bus_ack_o   = 1'b0;
				bus_rdata_o = '0;
			end
		endcase
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(core_cyc_o && data_mem_cyc_o))
		else $error("Both Wishbone ports selected");

	// Controller must have routed unmapped phases to the error path
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bus_req_i |-> !unmapped_o)
		else $error("Wishbone request for an unmapped address");

endmodule

`default_nettype wire

/* design/processorci_top.sv */
`timescale 1ns/1ns
`default_nettype none

module processorci_top
	import bus_pkg::*;
(
	input  logic              sys_clk_i,
	input  logic              rst_n_i,

	// AHB-Lite slave side, driven by the core
	input  logic [ADDR_W-1:0] haddr_i,
	input  logic              hwrite_i,
	input  logic [1:0]        htrans_i,
	input  logic [2:0]        hsize_i,
	input  logic [DATA_W-1:0] hwdata_i,
	output logic [DATA_W-1:0] hrdata_o,
	output logic              hready_o,
	output logic              hresp_o,

	// Code memory port
	output logic              core_cyc_o,
	output logic              core_stb_o,
	output logic              core_we_o,
	output logic [STRB_W-1:0] core_wstrb_o,
	output logic [ADDR_W-1:0] core_addr_o,
	output logic [DATA_W-1:0] core_data_o,
	input  logic [DATA_W-1:0] core_data_i,
	input  logic              core_ack_i,

	// Data memory port
	output logic              data_mem_cyc_o,
	output logic              data_mem_stb_o,
	output logic              data_mem_we_o,
	output logic [STRB_W-1:0] data_mem_wstrb_o,
	output logic [ADDR_W-1:0] data_mem_addr_o,
	output logic [DATA_W-1:0] data_mem_data_o,
	input  logic [DATA_W-1:0] data_mem_data_i,
	input  logic              data_mem_ack_i
);

	logic [ADDR_W-1:0] bus_addr;
	logic              phase_we;   // Write flag of the latched phase
	logic              bus_we;     // Qualified by the open cycle
	logic [STRB_W-1:0] bus_wstrb;
	logic [DATA_W-1:0] bus_wdata;
	logic [DATA_W-1:0] bus_rdata;
	logic              bus_ack;
	logic              bus_req;
	logic              misalign;
	logic              unmapped;
	logic              addr_load;
	logic              wdata_load;
	logic              rdata_load;

	ahb_wb_ctrl u_ctrl (
		.clk_i          (sys_clk_i),
		.rst_n_i        (rst_n_i),
		.htrans_i       (htrans_e'(htrans_i)),
		.hready_in_ok_i (phase_we),
		.misalign_i     (misalign),
		.unmapped_i     (unmapped),
		.bus_ack_i      (bus_ack),
		.hready_o       (hready_o),
		.hresp_o        (hresp_o),
		.addr_load_o    (addr_load),
		.wdata_load_o   (wdata_load),
		.rdata_load_o   (rdata_load),
		.bus_req_o      (bus_req),
		.bus_we_o       (bus_we)
	);

	ahb_wb_datapath u_datapath (
		.clk_i        (sys_clk_i),
		.rst_n_i      (rst_n_i),
		.haddr_i      (haddr_i),
		.hwrite_i     (hwrite_i),
		.hsize_i      (hsize_e'(hsize_i)),
		.hwdata_i     (hwdata_i),
		.addr_load_i  (addr_load),
		.wdata_load_i (wdata_load),
		.rdata_load_i (rdata_load),
		.bus_rdata_i  (bus_rdata),
		.addr_o       (bus_addr),
		.we_o         (phase_we),
		.wstrb_o      (bus_wstrb),
		.wdata_o      (bus_wdata),
		.hrdata_o     (hrdata_o),
		.misalign_o   (misalign)
	);

	wb_port_select u_select (
		.clk_i           (sys_clk_i),
		.rst_n_i         (rst_n_i),
		.addr_i          (bus_addr),
		.bus_req_i       (bus_req),
		.core_ack_i      (core_ack_i),
		.core_data_i     (core_data_i),
		.data_mem_ack_i  (data_mem_ack_i),
		.data_mem_data_i (data_mem_data_i),
		.unmapped_o      (unmapped),
		.core_cyc_o      (core_cyc_o),
		.core_stb_o      (core_stb_o),
		.data_mem_cyc_o  (data_mem_cyc_o),
		.data_mem_stb_o  (data_mem_stb_o),
		.bus_ack_o       (bus_ack),
		.bus_rdata_o     (bus_rdata)
	);

	// Shared nets, only cyc/stb tell the ports apart
	assign core_we_o        = bus_we;
	assign core_wstrb_o     = bus_wstrb;
	assign core_addr_o      = bus_addr;
	assign core_data_o      = bus_wdata;
	assign data_mem_we_o    = bus_we;
	assign data_mem_wstrb_o = bus_wstrb;
	assign data_mem_addr_o  = bus_addr;
	assign data_mem_data_o  = bus_wdata;

endmodule

`default_nettype wire

/* tb/wb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model #(
	parameter logic [31:0] base_addr = 32'h0000_0000
) (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  wstrb_i,
	input  logic [31:0] addr_i,
	input  logic [31:0] data_i,
	output logic        ack_o,
	output logic [31:0] data_o,
	output logic [31:0] access_cnt_o // Cycles served with an ack
);

	logic [31:0] mem [0:255]; // 1 KiB window above base_addr
	logic        busy;
	logic [1:0]  wait_q;
	logic [1:0]  left;
	logic [31:0] rnd;
	integer      seed;
	integer      j;
	integer      b;

	// Power-up content, different for every address
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	initial begin
		seed   = 32'hbc39;
		ack_o  = 1'b0;
		data_o = '0;
		for (j = 0; j < 256; j++)
			mem[j] = fill_word(base_addr | {22'b0, j[7:0], 2'b00});
	end

	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o        <= 1'b0;
			busy         <= 1'b0;
			wait_q       <= '0;
			access_cnt_o <= '0;
		end else if (ack_o) begin
			ack_o <= 1'b0; // Master drops cyc on this same edge
			busy  <= 1'b0;
		end else if (cyc_i && stb_i) begin
			if (!busy) begin
				rnd  = $random(seed);
				left = rnd[1:0]; // 0 to 3 extra cycles
			end else
				left = wait_q;
			busy <= 1'b1;
			if (left == 2'd0) begin
				if (we_i) begin
					for (b = 0; b < 4; b++)
						if (wstrb_i[b])
							mem[addr_i[9:2]][b*8 +: 8] <= data_i[b*8 +: 8];
				end
				data_o       <= mem[addr_i[9:2]];
				ack_o        <= 1'b1;
				access_cnt_o <= access_cnt_o + 1;
			end else
				wait_q <= left - 2'd1;
		end
	end

endmodule

`default_nettype wire

/* tb/tb_processorci_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_processorci_top
	import bus_pkg::*;
();

	localparam int num_rand    = 200;
	localparam int xfer_budget = num_rand + 150; // Directed tests issue fewer than 150
	localparam int timeout_ns  = xfer_budget * 8 * 10 + 500;

	typedef struct packed {
		logic        write;
		logic        exp_err;
		logic        resp;
		logic        err1_seen;
		logic [2:0]  size;
		logic [31:0] addr;
		logic [31:0] data; // Write data, or hrdata for a read
	} xfer_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] haddr;
	logic        hwrite;
	logic [1:0]  htrans;
	logic [2:0]  hsize;
	logic [31:0] hwdata;
	logic [31:0] hrdata;
	logic        hready;
	logic        hresp;
	logic        core_cyc;
	logic        core_stb;
	logic        core_we;
	logic [3:0]  core_wstrb;
	logic [31:0] core_addr;
	logic [31:0] core_wdata;
	logic [31:0] core_rdata;
	logic        core_ack;
	logic        data_mem_cyc;
	logic        data_mem_stb;
	logic        data_mem_we;
	logic [3:0]  data_mem_wstrb;
	logic [31:0] data_mem_addr;
	logic [31:0] data_mem_wdata;
	logic [31:0] data_mem_rdata;
	logic        data_mem_ack;
	logic [31:0] code_cnt;
	logic [31:0] data_cnt;

	logic [31:0] shadow [0:511]; // Code words then data words
	xfer_t       done_q[$];
	xfer_t       prev;
	xfer_t       done_rec;
	logic        prev_valid;
	integer      seed;
	integer      errors;
	integer      checks;

	processorci_top u_dut (
		.sys_clk_i        (clk),
		.rst_n_i          (rst_n),
		.haddr_i          (haddr),
		.hwrite_i         (hwrite),
		.htrans_i         (htrans),
		.hsize_i          (hsize),
		.hwdata_i         (hwdata),
		.hrdata_o         (hrdata),
		.hready_o         (hready),
		.hresp_o          (hresp),
		.core_cyc_o       (core_cyc),
		.core_stb_o       (core_stb),
		.core_we_o        (core_we),
		.core_wstrb_o     (core_wstrb),
		.core_addr_o      (core_addr),
		.core_data_o      (core_wdata),
		.core_data_i      (core_rdata),
		.core_ack_i       (core_ack),
		.data_mem_cyc_o   (data_mem_cyc),
		.data_mem_stb_o   (data_mem_stb),
		.data_mem_we_o    (data_mem_we),
		.data_mem_wstrb_o (data_mem_wstrb),
		.data_mem_addr_o  (data_mem_addr),
		.data_mem_data_o  (data_mem_wdata),
		.data_mem_data_i  (data_mem_rdata),
		.data_mem_ack_i   (data_mem_ack)
	);

	wb_mem_model #(.base_addr(32'h0000_0000)) u_code_mem (
		.clk_i (clk), .rst_n_i (rst_n), .cyc_i (core_cyc), .stb_i (core_stb),
		.we_i (core_we), .wstrb_i (core_wstrb), .addr_i (core_addr), .data_i (core_wdata),
		.ack_o (core_ack), .data_o (core_rdata), .access_cnt_o (code_cnt)
	);

	wb_mem_model #(.base_addr(32'h2000_0000)) u_data_mem (
		.clk_i (clk), .rst_n_i (rst_n), .cyc_i (data_mem_cyc), .stb_i (data_mem_stb),
		.we_i (data_mem_we), .wstrb_i (data_mem_wstrb), .addr_i (data_mem_addr),
		.data_i (data_mem_wdata), .ack_o (data_mem_ack), .data_o (data_mem_rdata),
		.access_cnt_o (data_cnt)
	);

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic logic [8:0] shadow_idx(input logic [31:0] a);
		return {a[29], a[9:2]};
	endfunction

	// Aligned, supported size and inside one of the two regions
	function automatic logic legal(input logic [31:0] a, input logic [2:0] s);
		logic mapped;
		mapped = (a[31:28] == 4'h0) || (a[31:28] == 4'h2);
		case (s)
			SZ_BYTE: return mapped;
			SZ_HALF: return mapped && !a[0];
			SZ_WORD: return mapped && (a[1:0] == 2'b00);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [3:0] lane_mask(input logic [31:0] a, input logic [2:0] s);
		case (s)
			SZ_BYTE: return 4'b0001 << a[1:0];
			SZ_HALF: return a[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [31:0] lane_bits(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	// Value moved down to bit 0, cut to size, then put back on its lanes
	function automatic logic [31:0] expected_read(input logic [31:0] a, input logic [2:0] s);
		logic [31:0] shifted;
		shifted = shadow[shadow_idx(a)] >> (8 * a[1:0]);
		case (s)
			SZ_BYTE: shifted = shifted & 32'h0000_00ff;
			SZ_HALF: shifted = shifted & 32'h0000_ffff;
			default: ;
		endcase
		return shifted << (8 * a[1:0]);
	endfunction

	task automatic merge_write(input logic [31:0] a, input logic [2:0] s, input logic [31:0] d);
		logic [3:0] strb;
		int         b;
		strb = lane_mask(a, s);
		for (b = 0; b < 4; b++)
			if (strb[b])
				shadow[shadow_idx(a)][b*8 +: 8] = d[b*8 +: 8];
	endtask

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
		end
	endtask

	// One address phase, overlapped with the data phase of the transfer before it
	task automatic issue(input logic [1:0] trans, input logic write, input logic [31:0] addr,
			input logic [2:0] size, input logic [31:0] wdata);
		xfer_t rec;
		logic  err1;
		haddr  = addr;
		hwrite = write;
		htrans = trans;
		hsize  = size;
		if (prev_valid && prev.write)
			hwdata = prev.data;
		err1 = 1'b0;
		while (!hready) begin
			if (hresp)
				err1 = 1'b1; // First error cycle
			@(negedge clk);
		end
		if (prev_valid) begin
			rec           = prev;
			rec.resp      = hresp;
			rec.err1_seen = err1;
			if (!rec.write)
				rec.data = hrdata;
			done_q.push_back(rec);
		end
		@(posedge clk);
		@(negedge clk);
		prev_valid   = (trans == TR_NONSEQ) || (trans == TR_SEQ);
		prev.write   = write;
		prev.addr    = addr;
		prev.size    = size;
		prev.data    = wdata;
		prev.exp_err = !legal(addr, size);
	endtask

	// Lone transfer, then the port counters tell which memory it reached
	task automatic routed_access(input logic write, input logic [31:0] addr,
			input logic [2:0] size, input logic [31:0] data);
		logic [31:0] code0;
		logic [31:0] data0;
		logic        ok;
		code0 = code_cnt;
		data0 = data_cnt;
		ok    = legal(addr, size);
		issue(TR_NONSEQ, write, addr, size, data);
		issue(TR_IDLE, 1'b0, 32'h0, SZ_WORD, 32'h0);
		compare(code_cnt - code0, ok && (addr[31:28] == 4'h0), "code port access count");
		compare(data_cnt - data0, ok && (addr[31:28] == 4'h2), "data port access count");
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Completed transfers in issue order, so the shadow is current at each read
	initial begin
		forever begin
			@(posedge clk);
			while (done_q.size() > 0) begin
				done_rec = done_q.pop_front();
				if (done_rec.exp_err) begin
					compare(done_rec.err1_seen, 1, "hresp high with hready low");
					compare(done_rec.resp, 1, "hresp in second error cycle");
				end else begin
					compare(done_rec.resp, 0, "hresp on a legal transfer");
					if (done_rec.write)
						merge_write(done_rec.addr, done_rec.size, done_rec.data);
					else
						compare(done_rec.data & lane_bits(lane_mask(done_rec.addr, done_rec.size)),
							expected_read(done_rec.addr, done_rec.size), "read data");
				end
			end
		end
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: the bridge stopped responding before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] base;
		logic [31:0] cnt0;
		logic [2:0]  size;
		integer      legal_n;
		integer      i;
		integer      r;
		seed       = 32'hbc39;
		errors     = 0;
		checks     = 0;
		prev_valid = 1'b0;
		haddr      = '0;
		hwrite     = 1'b0;
		htrans     = TR_IDLE;
		hsize      = SZ_WORD;
		hwdata     = '0;
		rst_n      = 1'b0;
		for (i = 0; i < 512; i++)
			shadow[i] = fill_word((i[8] ? DATA_BASE : CODE_BASE) | {22'b0, i[7:0], 2'b00});
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Quiet bus after reset, IDLE and BUSY start nothing
		compare(hready, 1, "hready after reset");
		compare(hresp, 0, "hresp after reset");
		compare({core_cyc, core_stb, data_mem_cyc, data_mem_stb}, 0, "cyc/stb after reset");
		for (i = 0; i < 6; i++) begin
			issue(i[0] ? TR_BUSY : TR_IDLE, 1'b1, DATA_BASE + i * 4, SZ_WORD, 32'h0);
			compare({core_cyc, data_mem_cyc}, 0, "cyc during IDLE/BUSY");
		end
		compare(code_cnt + data_cnt, 0, "accesses during IDLE/BUSY");

		// Word write and read back in each region
		for (r = 0; r < 2; r++) begin
			base = r ? DATA_BASE : CODE_BASE;
			routed_access(1'b0, base + 32'h200, SZ_WORD, 32'h0);
			for (i = 0; i < 3; i++) begin
				rnd = $random(seed);
				routed_access(1'b1, base + 32'h100 + i * 4, SZ_WORD, rnd);
				routed_access(1'b0, base + 32'h100 + i * 4, SZ_WORD, 32'h0);
			end
		end

		// Bytes at every offset, halves at both
		for (r = 0; r < 2; r++) begin
			base = (r ? DATA_BASE : CODE_BASE) + 32'h40;
			for (i = 0; i < 6; i++) begin
				rnd = $random(seed);
				if (i < 4)
					routed_access(1'b1, base + i, SZ_BYTE, rnd);
				else
					routed_access(1'b1, base + (i - 4) * 2, SZ_HALF, rnd);
				routed_access(1'b0, base, SZ_WORD, 32'h0);
			end
		end

		routed_access(1'b0, CODE_BASE + 32'h21, SZ_HALF, 32'h0);
		routed_access(1'b1, DATA_BASE + 32'h22, SZ_WORD, 32'hdead_beef);
		routed_access(1'b0, DATA_BASE + 32'h10, 3'b011, 32'h0); // Unsupported size
		routed_access(1'b1, 32'h4000_0010, SZ_WORD, 32'h1234_5678);

		// Back to back random mix
		cnt0    = code_cnt + data_cnt;
		legal_n = 0;
		for (i = 0; i < num_rand; i++) begin
			rnd = $random(seed);
			if (rnd[2:0] == 3'd0)
				issue(TR_IDLE, 1'b0, 32'h0, SZ_WORD, 32'h0);
			else begin
				size = (rnd[4:3] == 2'd0) ? SZ_BYTE : (rnd[4:3] == 2'd1) ? SZ_HALF : SZ_WORD;
				addr = (rnd[5] ? DATA_BASE : CODE_BASE) | {22'b0, rnd[13:6], 2'b00};
				if (size == SZ_BYTE)
					addr[1:0] = rnd[15:14];
				else if (size == SZ_HALF)
					addr[1] = rnd[15];
				issue(rnd[17] ? TR_SEQ : TR_NONSEQ, rnd[16], addr, size, $random(seed));
				legal_n++;
			end
		end
		issue(TR_IDLE, 1'b0, 32'h0, SZ_WORD, 32'h0);
		repeat (2) @(posedge clk);
		compare(code_cnt + data_cnt - cnt0, legal_n, "accesses in random mix");

		@(negedge clk);
		$display("Summary: %0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
design/bus_pkg.sv
design/ahb_wb_ctrl.sv
design/ahb_wb_datapath.sv
design/wb_port_select.sv
design/processorci_top.sv
tb/wb_mem_model.sv
tb/tb_processorci_top.sv
